// File: Makefile
# Verilator build and run for the static memory controller testbench

TOP = smc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// File: rtl/smc_counters.sv
// SMC access counters
// Leading-edge, wait-state and trailing-edge down-counters, loaded from
// the head entry in the store cycle and stepped by the state machine.
// The zero flags are decoded straight from the counter values
module smc_counters (
  input  logic                      sys_clk6,
  input  logic                      n_sys_reset6,
  input  logic                      load,
  input  logic [smc_pkg::req_w-1:0] head_data,
  input  logic                      le_enable,
  input  logic                      ws_enable,
  input  logic                      cste_enable,
  output logic                      le_zero,
  output logic                      ws_zero,
  output logic                      cste_zero
);
  import smc_pkg::*;

  logic [csle_w-1:0] le_count;                // LE cycles left after this one
  logic [ws_w-1:0]   ws_count;                // RW cycles left after this one
  logic [cste_w-1:0] cste_count;              // Float cycles still to run

  // ------------------------------------------------------------
  // Leading edge
  // ------------------------------------------------------------
  // Loaded one short, so LE lasts exactly csle cycles
  // Value unused when csle is zero, LE is skipped then
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      le_count <= '0;
    else if (load)
      le_count <= head_data[csle_lsb +: csle_w] - 1'b1;
    else if (le_enable)
      le_count <= le_count - 1'b1;
  end

  // ------------------------------------------------------------
  // Wait states
  // ------------------------------------------------------------
  // RW runs from ws down to zero, ws+1 cycles
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      ws_count <= '0;
    else if (load)
      ws_count <= head_data[ws_lsb +: ws_w];
    else if (ws_enable)
      ws_count <= ws_count - 1'b1;
  end

  // ------------------------------------------------------------
  // Trailing edge
  // ------------------------------------------------------------
  // Stepped on every edge into float, including the RW exit,
  // so float holds for cste cycles
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      cste_count <= '0;
    else if (load)
      cste_count <= head_data[cste_lsb +: cste_w];
    else if (cste_enable)
      cste_count <= cste_count - 1'b1;
  end

  // Zero flags
  assign le_zero   = (le_count == '0);
  assign ws_zero   = (ws_count == '0);
  assign cste_zero = (cste_count == '0);

endmodule

// File: rtl/smc_host_if.sv
// SMC host interface
// Holds the three timing registers written by the host and turns each
// request strobe into one queue push, packing the access with a
// snapshot of the timing registers as they stood before that edge
module smc_host_if (
  input  logic                       sys_clk6,
  input  logic                       n_sys_reset6,
  input  logic                       cfg_wr,
  input  logic [smc_pkg::csle_w-1:0] cfg_csle,
  input  logic [smc_pkg::ws_w-1:0]   cfg_ws,
  input  logic [smc_pkg::cste_w-1:0] cfg_cste,
  input  logic                       req_valid,
  input  logic                       req_write,
  input  logic [smc_pkg::addr_w-1:0] req_addr,
  input  logic [smc_pkg::data_w-1:0] req_wdata,
  output logic                       push,
  output logic [smc_pkg::req_w-1:0]  push_data
);
  import smc_pkg::*;

  logic [csle_w-1:0] csle_r;                  // Current leading edge setting
  logic [ws_w-1:0]   ws_r;                    // Current wait states
  logic [cste_w-1:0] cste_r;                  // Current trailing edge setting

  // ------------------------------------------------------------
  // Timing configuration registers
  // ------------------------------------------------------------
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      csle_r <= '0;
      ws_r   <= '0;
      cste_r <= '0;
    end
    else if (cfg_wr)
    begin
      csle_r <= cfg_csle;
      ws_r   <= cfg_ws;
      cste_r <= cfg_cste;
    end
  end

  // Push strobe, one cycle behind req_valid
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      push <= 1'b0;
    else
      push <= req_valid;
  end

  // ------------------------------------------------------------
  // Entry packing
  // ------------------------------------------------------------
  // Old settings win when cfg_wr and req_valid share a cycle
  always_ff @(posedge sys_clk6)
  begin
    if (req_valid)
    begin
      push_data[write_bit]              <= req_write;
      push_data[addr_lsb +: addr_w]     <= req_addr;
      push_data[wdata_lsb +: data_w]    <= req_wdata;
      push_data[csle_lsb +: csle_w]     <= csle_r;   // Snapshot
      push_data[ws_lsb +: ws_w]         <= ws_r;
      push_data[cste_lsb +: cste_w]     <= cste_r;
    end
  end

endmodule

// File: rtl/smc_pkg.sv
// Static memory controller shared definitions
// Bus widths, timing field sizes, request queue geometry, the packed
// request layout and the access state encoding
package smc_pkg;

  // ------------------------------------------------------------
  // Memory bus
  // ------------------------------------------------------------
  localparam int addr_w = 16;                 // Word address
  localparam int data_w = 16;                 // One 16-bit word per access

  // Timing settings, snapshotted per request
  localparam int csle_w = 2;                  // CS leading edge, 0..3 cycles
  localparam int ws_w   = 8;                  // Wait states, 0..255
  localparam int cste_w = 2;                  // CS trailing edge, 0..3 cycles

  // ------------------------------------------------------------
  // Request queue
  // ------------------------------------------------------------
  localparam int queue_depth = 4;
  localparam int queue_ptr_w = $clog2(queue_depth);      // Power of two depth
  localparam int queue_cnt_w = $clog2(queue_depth + 1);  // Holds 0..depth

  // Packed entry layout, LSB first
  localparam int cste_lsb  = 0;
  localparam int ws_lsb    = cste_lsb + cste_w;
  localparam int csle_lsb  = ws_lsb + ws_w;
  localparam int wdata_lsb = csle_lsb + csle_w;
  localparam int addr_lsb  = wdata_lsb + data_w;
  localparam int write_bit = addr_lsb + addr_w;      // 1 = write access
  localparam int req_w     = write_bit + 1;          // 45 bits in all

  // Access sequence
  typedef enum logic [2:0] {
    idle  = 3'd0,                             // Nothing pending, CS high
    store = 3'd1,                             // Pop and load counters
    le    = 3'd2,                             // CS only, leading edge
    rw    = 3'd3,                             // OE or WE low
    float = 3'd4                              // CS only, trailing edge
  } smc_state_e;

endpackage

// File: rtl/smc_req_fifo.sv
// SMC request queue
// Circular buffer between the host interface and the timing engine,
// with read and write pointers and an occupancy count. The head entry
// is always visible; a push while full is dropped
module smc_req_fifo (
  input  logic                      sys_clk6,
  input  logic                      n_sys_reset6,
  input  logic                      push,
  input  logic [smc_pkg::req_w-1:0] push_data,
  input  logic                      pop,
  output logic [smc_pkg::req_w-1:0] head_data,
  output logic                      queue_empty,
  output logic                      queue_full
);
  import smc_pkg::*;

  logic [req_w-1:0]       mem [queue_depth];  // Entry storage
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_ptr_w-1:0] rd_ptr;
  logic [queue_cnt_w-1:0] count;              // Entries held
  logic                   do_push;
  logic                   do_pop;

  assign do_push = push && !queue_full;
  assign do_pop  = pop && !queue_empty;

  // Flags straight from the count
  assign queue_empty = (count == '0);
  assign queue_full  = (count == queue_cnt_w'(queue_depth));

  assign head_data = mem[rd_ptr];             // Oldest entry

  // ------------------------------------------------------------
  // Storage write
  // ------------------------------------------------------------
  always_ff @(posedge sys_clk6)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Push and pop together leave count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: rtl/smc_state.sv
// SMC access state machine
// Sequences idle, store, leading edge, read/write and float for each
// queued request, drives chip select and the two strobes from the
// state, holds address and write data for the whole access, latches
// read data and raises the completion strobes. A waiting request is
// started straight from the end of the previous access
module smc_state (
  input  logic                       sys_clk6,
  input  logic                       n_sys_reset6,
  input  logic                       queue_empty,
  input  logic [smc_pkg::req_w-1:0]  head_data,
  input  logic                       le_zero,
  input  logic                       ws_zero,
  input  logic                       cste_zero,
  input  logic [smc_pkg::data_w-1:0] mem_rdata,
  output logic                       pop,
  output logic                       load,
  output logic                       le_enable,
  output logic                       ws_enable,
  output logic                       cste_enable,
  output logic                       mem_cs_n,
  output logic                       mem_oe_n,
  output logic                       mem_we_n,
  output logic [smc_pkg::addr_w-1:0] mem_addr,
  output logic [smc_pkg::data_w-1:0] mem_wdata,
  output logic                       rd_valid,
  output logic [smc_pkg::data_w-1:0] rd_data,
  output logic                       acc_done,
  output logic                       smc_idle
);
  import smc_pkg::*;

  smc_state_e state;                          // Registered state
  smc_state_e next_state;
  logic       write_r;                        // Direction of current access
  logic       done;                           // Last cycle of an access
  logic       latch_data;                     // Sample mem_rdata this cycle

  // ------------------------------------------------------------
  // Access end and read sample points
  // ------------------------------------------------------------
  assign done = ((state == rw) && ws_zero && cste_zero) ||
                ((state == float) && cste_zero);

  assign latch_data = (state == rw) && ws_zero && !write_r;  // Last RW cycle

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb
  begin
    next_state = state;
    case (state)
      idle:
        if (!queue_empty)
          next_state = store;
      store:
        if (head_data[csle_lsb +: csle_w] != '0)  // Counters not loaded yet
          next_state = le;
        else
          next_state = rw;
      le:
        if (le_zero)
          next_state = rw;
      rw:
        if (ws_zero)
        begin
          if (!cste_zero)
            next_state = float;
          else if (!queue_empty)
            next_state = store;                 // Back-to-back, CS held
          else
            next_state = idle;
        end
      float:
        if (cste_zero)
          next_state = queue_empty ? idle : store;
      default:
        next_state = idle;
    endcase
  end

  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      state <= idle;
    else
      state <= next_state;
  end

  // Queue and counter control
  assign pop         = (state == store);
  assign load        = (state == store);     // Same cycle as the pop
  assign le_enable   = (state == le) && !le_zero;
  assign ws_enable   = (state == rw) && !ws_zero;
  assign cste_enable = (next_state == float);

  // ------------------------------------------------------------
  // Access registers, captured on the pop
  // ------------------------------------------------------------
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      write_r <= 1'b0;
    else if (pop)
      write_r <= head_data[write_bit];
  end

  always_ff @(posedge sys_clk6)
  begin
    if (pop)
    begin
      mem_addr  <= head_data[addr_lsb +: addr_w];   // Held until next store
      mem_wdata <= head_data[wdata_lsb +: data_w];
    end
    if (latch_data)
      rd_data <= mem_rdata;
  end

  // Memory pins from the state
  assign mem_cs_n = (state == idle);
  assign mem_oe_n = !((state == rw) && !write_r);
  assign mem_we_n = !((state == rw) && write_r);

  // ------------------------------------------------------------
  // Completion strobes, cycle after the access ends
  // ------------------------------------------------------------
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      acc_done <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      acc_done <= done;
      rd_valid <= done && !write_r;           // Reads only
    end
  end

  assign smc_idle = (state == idle);

endmodule

// File: rtl/smc_top.sv
// Static memory controller top level
// Host interface feeding a four-entry request queue, drained by the
// access state machine and its timing counters toward one SRAM bank
module smc_top (
  input  logic                       sys_clk6,
  input  logic                       n_sys_reset6,
  input  logic                       cfg_wr,
  input  logic [smc_pkg::csle_w-1:0] cfg_csle,
  input  logic [smc_pkg::ws_w-1:0]   cfg_ws,
  input  logic [smc_pkg::cste_w-1:0] cfg_cste,
  input  logic                       req_valid,
  input  logic                       req_write,
  input  logic [smc_pkg::addr_w-1:0] req_addr,
  input  logic [smc_pkg::data_w-1:0] req_wdata,
  output logic                       queue_full,
  output logic                       rd_valid,
  output logic [smc_pkg::data_w-1:0] rd_data,
  output logic                       acc_done,
  output logic                       smc_idle,
  output logic                       mem_cs_n,
  output logic                       mem_oe_n,
  output logic                       mem_we_n,
  output logic [smc_pkg::addr_w-1:0] mem_addr,
  output logic [smc_pkg::data_w-1:0] mem_wdata,
  input  logic [smc_pkg::data_w-1:0] mem_rdata
);
  import smc_pkg::*;

  logic             push;                     // Host IF to queue
  logic [req_w-1:0] push_data;
  logic             pop;                      // Engine to queue
  logic             load;                     // Engine to counters
  logic [req_w-1:0] head_data;
  logic             queue_empty;
  logic             le_enable;
  logic             ws_enable;
  logic             cste_enable;
  logic             le_zero;
  logic             ws_zero;
  logic             cste_zero;

  // ------------------------------------------------------------
  // Producer, buffer, consumer
  // ------------------------------------------------------------
  smc_host_if smc_host_if_i (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .cfg_wr       (cfg_wr),
    .cfg_csle     (cfg_csle),
    .cfg_ws       (cfg_ws),
    .cfg_cste     (cfg_cste),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .push         (push),
    .push_data    (push_data)
  );

  smc_req_fifo smc_req_fifo_i (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .push         (push),
    .push_data    (push_data),
    .pop          (pop),
    .head_data    (head_data),
    .queue_empty  (queue_empty),
    .queue_full   (queue_full)
  );

  smc_counters smc_counters_i (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .load         (load),
    .head_data    (head_data),
    .le_enable    (le_enable),
    .ws_enable    (ws_enable),
    .cste_enable  (cste_enable),
    .le_zero      (le_zero),
    .ws_zero      (ws_zero),
    .cste_zero    (cste_zero)
  );

  smc_state smc_state_i (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .queue_empty  (queue_empty),
    .head_data    (head_data),
    .le_zero      (le_zero),
    .ws_zero      (ws_zero),
    .cste_zero    (cste_zero),
    .mem_rdata    (mem_rdata),
    .pop          (pop),
    .load         (load),
    .le_enable    (le_enable),
    .ws_enable    (ws_enable),
    .cste_enable  (cste_enable),
    .mem_cs_n     (mem_cs_n),
    .mem_oe_n     (mem_oe_n),
    .mem_we_n     (mem_we_n),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .acc_done     (acc_done),
    .smc_idle     (smc_idle)
  );

endmodule

// File: sim.f
rtl/smc_pkg.sv
rtl/smc_host_if.sv
rtl/smc_req_fifo.sv
rtl/smc_counters.sv
rtl/smc_state.sv
rtl/smc_top.sv
tb/smc_tb_sva.sv
tb/smc_tb.sv

// File: tb/smc_tb.sv
// SMC testbench
// Drives a table of configured reads and writes into the controller,
// models a 16-word asynchronous SRAM, and checks read data, strobe
// timing per snapshotted settings, back-to-back chip select and idle
module smc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import smc_pkg::*;

  localparam int n_entries  = 13;
  localparam int clk_half   = 2;              // 4 ns period
  localparam int acc_max    = 2 + 3 + 255 + 3 + 4;
  localparam int watchdog_ns = n_entries * acc_max * 4 + 80;

  typedef struct packed {
    logic [csle_w-1:0] csle;
    logic [ws_w-1:0]   ws;
    logic [cste_w-1:0] cste;
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [data_w-1:0] exp;                   // Expected read data
  } entry_t;

  logic              sys_clk6;
  logic              n_sys_reset6;
  logic              cfg_wr;
  logic [csle_w-1:0] cfg_csle;
  logic [ws_w-1:0]   cfg_ws;
  logic [cste_w-1:0] cfg_cste;
  logic              req_valid;
  logic              req_write;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_wdata;
  logic              queue_full;
  logic              rd_valid;
  logic [data_w-1:0] rd_data;
  logic              acc_done;
  logic              smc_idle;
  logic              mem_cs_n;
  logic              mem_oe_n;
  logic              mem_we_n;
  logic [addr_w-1:0] mem_addr;
  logic [data_w-1:0] mem_wdata;
  logic [data_w-1:0] mem_rdata;

  entry_t            stim [n_entries];
  logic [data_w-1:0] sram [16];               // SRAM model contents
  logic [data_w-1:0] shadow [16];             // Expected contents
  logic [31:0]       lfsr_state;
  int                req_cyc [n_entries];     // Cycle each request was driven
  int                issued;
  int                done_cnt;
  int                cyc;
  int                phase;                   // 0 lead, 1 strobe, 2 trail
  int                lead;
  int                rw_len;
  int                post;

  smc_top smc_top_i (.*);

  // ------------------------------------------------------------
  // Clock, cycle count, SRAM model
  // ------------------------------------------------------------
  initial sys_clk6 = 1'b0;
  always #clk_half sys_clk6 = ~sys_clk6;

  always @(posedge sys_clk6)
    cyc = cyc + 1;

  assign mem_rdata = mem_oe_n ? 16'h0000 : sram[mem_addr[3:0]];

  always @(posedge mem_we_n)
  begin
    if (n_sys_reset6)
      sram[mem_addr[3:0]] = mem_wdata;        // Write on WE rising
  end

  function automatic logic [data_w-1:0] fill_word(input int idx);
    logic [3:0] a;
    a = 4'(idx);
    return {a, ~a, a ^ 4'h9, 4'h3} ^ 16'h5A5A;
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [data_w-1:0] w);
    w = '0;
    for (int i = 0; i < data_w; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[data_w-2:0], lfsr_state[0]};     // One bit per step
    end
  endtask

  // ------------------------------------------------------------
  // Failure reporting
  // ------------------------------------------------------------
  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic fail_now(input string msg);
    $display("Error: %s", msg);
    stop_run();
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
      stop_run();
    end
  endtask

  task automatic check_quiet_pins();
    check("mem_cs_n", 32'(mem_cs_n), 32'd1);
    check("mem_oe_n", 32'(mem_oe_n), 32'd1);
    check("mem_we_n", 32'(mem_we_n), 32'd1);
    check("rd_valid", 32'(rd_valid), 32'd0);
    check("acc_done", 32'(acc_done), 32'd0);
    check("queue_full", 32'(queue_full), 32'd0);
  endtask

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  task automatic set_row(input int k, input int csle, input int ws, input int cste,
                         input bit wr, input int addr);
    stim[k].csle = csle_w'(csle);
    stim[k].ws   = ws_w'(ws);
    stim[k].cste = cste_w'(cste);
    stim[k].wr   = wr;
    stim[k].addr = addr_w'(addr);
    stim[k].data = '0;
    stim[k].exp  = '0;
  endtask

  task automatic build_table();
    logic [data_w-1:0] w;
    set_row(0,  1, 2,   1, 1'b1, 3);
    set_row(1,  1, 2,   1, 1'b0, 3);
    set_row(2,  0, 0,   0, 1'b1, 5);
    set_row(3,  0, 0,   0, 1'b0, 5);
    set_row(4,  3, 10,  3, 1'b1, 7);
    set_row(5,  3, 10,  3, 1'b1, 8);
    set_row(6,  2, 255, 2, 1'b0, 7);          // Long access, queue fills behind it
    set_row(7,  0, 1,   0, 1'b0, 8);
    set_row(8,  0, 1,   0, 1'b1, 9);
    set_row(9,  1, 0,   2, 1'b0, 9);
    set_row(10, 1, 0,   2, 1'b0, 0);          // Untouched word
    set_row(11, 3, 4,   0, 1'b1, 15);
    set_row(12, 3, 4,   0, 1'b0, 15);
    // Write data and expected read data
    for (int k = 0; k < n_entries; k++)
    begin
      if (stim[k].wr)
      begin
        rand_word(w);
        stim[k].data = w;
        shadow[stim[k].addr[3:0]] = w;
      end
      else
        stim[k].exp = shadow[stim[k].addr[3:0]];
    end
  endtask

  // ------------------------------------------------------------
  // Access monitor, sampled on falling edges
  // ------------------------------------------------------------
  task automatic track_access();
    logic strobe_low;
    logic other_low;
    bit   next_ready;
    strobe_low = stim[done_cnt].wr ? !mem_we_n : !mem_oe_n;
    other_low  = stim[done_cnt].wr ? !mem_oe_n : !mem_we_n;
    if (other_low && !acc_done)
      fail_now("wrong strobe driven for the current access");
    if (strobe_low)
    begin
      check("mem_addr", 32'(mem_addr), 32'(stim[done_cnt].addr));  // Held through the strobe
      if (stim[done_cnt].wr)
        check("mem_wdata", 32'(mem_wdata), 32'(stim[done_cnt].data));
    end
    if (rd_valid)
    begin
      if (!acc_done)
        fail_now("rd_valid without acc_done");
      if (stim[done_cnt].wr)
        fail_now("rd_valid after a write access");
      check("rd_data", 32'(rd_data), 32'(stim[done_cnt].exp));
    end
    if (acc_done)
    begin
      if (done_cnt >= issued)
        fail_now("acc_done with no request outstanding");
      check("lead cycles", 32'(lead), 32'(stim[done_cnt].csle) + 32'd1);
      check("strobe cycles", 32'(rw_len), 32'(stim[done_cnt].ws) + 32'd1);
      check("trail cycles", 32'(post + 1), 32'(stim[done_cnt].cste) + 32'd1);
      // Next request queued by the done cycle starts without idle
      next_ready = (done_cnt + 1 < issued) && (req_cyc[done_cnt + 1] <= cyc - 3);
      check("mem_cs_n", 32'(mem_cs_n), next_ready ? 32'd0 : 32'd1);
      check("smc_idle", 32'(smc_idle), next_ready ? 32'd0 : 32'd1);
      done_cnt = done_cnt + 1;
      phase  = 0;
      lead   = mem_cs_n ? 0 : 1;             // This cycle may be the next store
      rw_len = 0;
      post   = 0;
    end
    else
    begin
      case (phase)
        0:
          if (strobe_low)
          begin
            phase  = 1;
            rw_len = 1;
          end
          else if (!mem_cs_n)
            lead = lead + 1;
        1:
          if (strobe_low)
            rw_len = rw_len + 1;
          else
          begin
            phase = 2;
            post  = 1;
          end
        default:
          post = post + 1;
      endcase
      if (mem_cs_n && (phase != 0 || lead != 0))
        fail_now("chip select rose in the middle of an access");
    end
  endtask

  always @(negedge sys_clk6)
  begin
    if (n_sys_reset6)
      track_access();
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    logic [csle_w-1:0] cur_csle;
    logic [ws_w-1:0]   cur_ws;
    logic [cste_w-1:0] cur_cste;
    n_sys_reset6 = 1'b0;
    cfg_wr       = 1'b0;
    cfg_csle     = '0;
    cfg_ws       = '0;
    cfg_cste     = '0;
    req_valid    = 1'b0;
    req_write    = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    cyc = 0;
    issued = 0;
    done_cnt = 0;
    phase = 0;
    lead = 0;
    rw_len = 0;
    post = 0;
    lfsr_state = 32'h59298d58;
    cur_csle = '0;                            // DUT reset settings
    cur_ws   = '0;
    cur_cste = '0;
    for (int i = 0; i < 16; i++)
    begin
      sram[i]   = fill_word(i);
      shadow[i] = fill_word(i);
    end
    build_table();

    repeat (2)
    begin
      @(negedge sys_clk6);
      check_quiet_pins();                     // Held in reset
    end
    n_sys_reset6 = 1'b1;
    @(negedge sys_clk6);
    check_quiet_pins();
    check("smc_idle", 32'(smc_idle), 32'd1);

    for (int k = 0; k < n_entries; k++)
    begin
      // New settings while earlier requests still wait in the queue
      if (stim[k].csle != cur_csle || stim[k].ws != cur_ws || stim[k].cste != cur_cste)
      begin
        cfg_wr   = 1'b1;
        cfg_csle = stim[k].csle;
        cfg_ws   = stim[k].ws;
        cfg_cste = stim[k].cste;
        cur_csle = stim[k].csle;
        cur_ws   = stim[k].ws;
        cur_cste = stim[k].cste;
        @(negedge sys_clk6);
        cfg_wr = 1'b0;
      end
      while (queue_full)
        @(negedge sys_clk6);
      req_valid  = 1'b1;
      req_write  = stim[k].wr;
      req_addr   = stim[k].addr;
      req_wdata  = stim[k].data;
      req_cyc[k] = cyc;
      issued     = k + 1;
      @(negedge sys_clk6);
      req_valid = 1'b0;
      @(negedge sys_clk6);                    // Let queue_full catch up
    end

    while (done_cnt < n_entries)
      @(negedge sys_clk6);
    @(negedge sys_clk6);
    check("smc_idle", 32'(smc_idle), 32'd1);
    repeat (4) @(negedge sys_clk6);           // Window for a stray acc_done
    for (int i = 0; i < 16; i++)
      check("sram word", 32'(sram[i]), 32'(shadow[i]));
    check("assertion failures", 32'(smc_top_i.smc_tb_sva_i.fail_count), 32'd0);

    $display("TEST PASS");
    $finish;
  end

  // Watchdog sized for the longest possible access per entry
  initial
  begin
    #(watchdog_ns);
    $display("Error: watchdog expired before all accesses completed");
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

endmodule

// File: tb/smc_tb_sva.sv
// SMC protocol assertions
// Bound into the controller top level; checks queue use by the host,
// strobe exclusivity and chip select framing, and read completions
module smc_tb_sva (
  input logic sys_clk6,
  input logic n_sys_reset6,
  input logic push,
  input logic queue_full,
  input logic mem_cs_n,
  input logic mem_oe_n,
  input logic mem_we_n,
  input logic rd_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  logic last_read;                            // Last strobe seen was OE
  int   fail_count = 0;                       // Assertion failures so far

  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      last_read <= 1'b0;
    else if (!mem_oe_n)
      last_read <= 1'b1;
    else if (!mem_we_n)
      last_read <= 1'b0;
  end

  // ------------------------------------------------------------
  // Properties
  // ------------------------------------------------------------
  no_push_when_full: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    push |-> !queue_full)
  else
  begin
    fail_count = fail_count + 1;
    $error("push into a full request queue");
  end

  strobes_exclusive: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    !(!mem_oe_n && !mem_we_n))
  else
  begin
    fail_count = fail_count + 1;
    $error("OE and WE low together");
  end

  strobe_inside_cs: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    (!mem_oe_n || !mem_we_n) |-> !mem_cs_n)
  else
  begin
    fail_count = fail_count + 1;
    $error("strobe low while chip select high");
  end

  rd_valid_after_read: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    rd_valid |-> last_read)
  else
  begin
    fail_count = fail_count + 1;
    $error("rd_valid after a write access");
  end

endmodule

bind smc_top smc_tb_sva smc_tb_sva_i (
  .sys_clk6     (sys_clk6),
  .n_sys_reset6 (n_sys_reset6),
  .push         (push),
  .queue_full   (queue_full),
  .mem_cs_n     (mem_cs_n),
  .mem_oe_n     (mem_oe_n),
  .mem_we_n     (mem_we_n),
  .rd_valid     (rd_valid)
);
